// ==== all.f ====
source/cvt_pkg.sv
source/cvt_pipe_reg.sv
source/cvt_lzc.sv
source/cvt_round.sv
source/cvt_issue.sv
source/cvt_lane.sv
source/cvt_collect.sv
source/cvt_itof.sv
test/cvt_checker.sv
test/tb_cvt_itof.sv

// ==== Bender.yml ====
package:
  name: cvt_itof

sources:
  - source/cvt_pkg.sv
  - source/cvt_pipe_reg.sv
  - source/cvt_lzc.sv
  - source/cvt_round.sv
  - source/cvt_issue.sv
  - source/cvt_lane.sv
  - source/cvt_collect.sv
  - source/cvt_itof.sv
  - target: test
    files:
      - test/cvt_checker.sv
      - test/tb_cvt_itof.sv

// ==== test/tb_cvt_itof.sv ====
`timescale 1ns/1ps

module tb_cvt_itof;

    import cvt_pkg::*;

    localparam int          N_REQ           = 10 + 10 + 200 + 150 + 1;
    localparam int          WATCHDOG_CYCLES = N_REQ * 4 + 200;
    localparam logic [15:0] LFSR_SEED       = 16'd21732;

    logic        clk;
    logic        reset_i;
    logic        valid_i;
    logic        ready_o;
    logic        valid_o;
    logic        ready_i;
    cvt_req_t    req_i;
    cvt_rsp_t    rsp_o;
    int          err_cnt;
    int          check_cnt;
    int          pending;
    int          prev_checks;
    int          prev_errs;
    logic [15:0] lfsr;
    logic        bp_on;   // random ready_i when set
    logic [TAG_W-1:0] next_tag;

    cvt_itof u_cvt_itof (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (valid_i),
        .ready_o (ready_o),
        .req_i   (req_i),
        .valid_o (valid_o),
        .ready_i (ready_i),
        .rsp_o   (rsp_o)
    );

    cvt_checker u_checker (
        .clk         (clk),
        .reset_i     (reset_i),
        .valid_i     (valid_i),
        .ready_o     (ready_o),
        .req_i       (req_i),
        .valid_o     (valid_o),
        .ready_i     (ready_i),
        .rsp_o       (rsp_o),
        .err_cnt_o   (err_cnt),
        .check_cnt_o (check_cnt),
        .pending_o   (pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic step_ready();
        logic [31:0] bits;
        draw(1, bits);
        ready_i = bp_on ? bits[0] : 1'b1;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        @(negedge clk);
        step_ready();
    endtask

    // holds the request until an edge with ready_o high
    task automatic send(input logic [LANES-1:0][INT_W-1:0] data, input logic sgn,
                        input rnd_mode_e mode);
        logic taken;
        req_i.tag       = next_tag;
        req_i.rnd_mode  = mode;
        req_i.is_signed = sgn;
        req_i.data      = data;
        valid_i         = 1'b1;
        next_tag++;
        do begin
            @(posedge clk);
            taken = ready_o;
            @(negedge clk);
            step_ready();
        end while (!taken);
        valid_i = 1'b0;
    endtask

    task automatic send_random();
        logic [31:0]                 bits;
        logic [LANES-1:0][INT_W-1:0] data;
        logic                        sgn;
        rnd_mode_e                   mode;
        draw(2, bits);
        if (bits == 0) begin
            idle_cycle();   // input bubble
        end
        for (int i = 0; i < LANES; i++) begin
            draw(32, bits);
            data[i] = bits;
            draw(2, bits);
            if (bits == 0) begin   // small magnitudes now and then
                draw(5, bits);
                data[i] = data[i] >> bits;
            end
        end
        draw(1, bits);
        sgn = bits[0];
        draw(3, bits);
        mode = rnd_mode_e'(3'(bits % 5));
        send(data, sgn, mode);
    endtask

    task automatic end_test(input string name);
        while (pending != 0) begin
            idle_cycle();
        end
        $display("test %s: %0d responses checked, %0d errors",
                 name, check_cnt - prev_checks, err_cnt - prev_errs);
        prev_checks = check_cnt;
        prev_errs   = err_cnt;
    endtask

    initial begin
        lfsr        = LFSR_SEED;
        bp_on       = 1'b0;
        next_tag    = '0;
        prev_checks = 0;
        prev_errs   = 0;
        reset_i     = 1'b1;
        valid_i     = 1'b0;
        ready_i     = 1'b1;
        req_i       = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        idle_cycle();
        idle_cycle();
        end_test("reset state");

        for (int m = 0; m < 5; m++) begin
            send({32'h0100_0000, 32'hFFFF_FFFF, 32'd1, 32'd0}, 1'b1, rnd_mode_e'(m));
            send({32'd2, 32'd64, 32'h4000_0000, 32'h8000_0000}, 1'b1, rnd_mode_e'(m));
        end
        end_test("exact values");

        // 0x7fffffff carries into the exponent
        for (int m = 0; m < 5; m++) begin
            send({32'd16777217, 32'd16777219, 32'd33554435, 32'h7FFF_FFFF}, 1'b1,
                 rnd_mode_e'(m));
            send({-32'd16777217, -32'd16777219, -32'd33554435, 32'h8000_0001}, 1'b1,
                 rnd_mode_e'(m));
        end
        end_test("rounding cases");

        repeat (200) send_random();
        end_test("random inputs");

        bp_on = 1'b1;
        repeat (150) send_random();
        end_test("back-pressure");
        bp_on = 1'b0;
        idle_cycle();

        send({32'd3, 32'hFFFF_FFF0, 32'd1000, 32'h1234_5678}, 1'b1, RNE);
        end_test("latency");

        $display("done: %0d responses checked, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0 && check_cnt == N_REQ) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles with %0d responses still outstanding",
                 WATCHDOG_CYCLES, pending);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== test/cvt_checker.sv ====
`timescale 1ns/1ps

module cvt_checker (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              valid_i,
    input  logic              ready_o,
    input  cvt_pkg::cvt_req_t req_i,
    input  logic              valid_o,
    input  logic              ready_i,
    input  cvt_pkg::cvt_rsp_t rsp_o,
    output int                err_cnt_o,
    output int                check_cnt_o,
    output int                pending_o
);

    import cvt_pkg::*;

    cvt_rsp_t exp_q[$];
    longint   due_q[$];   // accept cycle + 4 less the stalls seen so far
    longint   cycle;
    longint   stalls;     // edges with the whole pipeline frozen
    logic     reset_q;

    // rounds the integer value by comparing the dropped part with half an ulp
    function automatic cvt_lane_rsp_t ref_convert(input logic [INT_W-1:0] x, input logic sgn,
                                                  input rnd_mode_e mode);
        cvt_lane_rsp_t   r;
        logic            neg;
        logic            up;
        longint unsigned mag;
        longint unsigned q;
        longint unsigned rem;
        longint unsigned half;
        int              p;
        neg = sgn & x[INT_W-1];
        mag = neg ? (64'd1 << INT_W) - x : x;
        r   = '0;
        if (mag == 0) begin
            return r;   // +0, exact
        end
        p = 0;
        for (int i = 0; i < 64; i++) begin
            if ((mag >> i) != 0) begin
                p = i;   // msb position
            end
        end
        if (p <= MAN_BITS) begin
            q    = mag << (MAN_BITS - p);
            rem  = 0;
            half = 0;
        end else begin
            q    = mag >> (p - MAN_BITS);
            rem  = mag - (q << (p - MAN_BITS));
            half = 64'd1 << (p - MAN_BITS - 1);
        end
        case (mode)
            RNE:     up = (rem > half) || (rem != 0 && rem == half && q[0]);
            RDN:     up = neg && rem != 0;
            RUP:     up = !neg && rem != 0;
            RMM:     up = rem != 0 && rem >= half;
            default: up = 1'b0;
        endcase
        q = q + up;
        if ((q >> (MAN_BITS + 1)) != 0) begin   // rounded up to the next power of two
            q = q >> 1;
            p++;
        end
        r.result = {neg, EXP_BITS'(EXP_BIAS + p), MAN_BITS'(q)};
        r.nx     = rem != 0;
        return r;
    endfunction

    function automatic cvt_rsp_t expected_response(input cvt_req_t req);
        cvt_rsp_t      rsp;
        cvt_lane_rsp_t lane;
        rsp.tag = req.tag;
        for (int i = 0; i < LANES; i++) begin
            lane          = ref_convert(req.data[i], req.is_signed, req.rnd_mode);
            rsp.result[i] = lane.result;
            rsp.nx[i]     = lane.nx;
        end
        return rsp;
    endfunction

    always @(posedge clk) begin : monitor
        cvt_rsp_t exp_rsp;
        longint   due;
        if (reset_i) begin
            exp_q.delete();
            due_q.delete();
            cycle       = 0;
            stalls      = 0;
            err_cnt_o   = 0;
            check_cnt_o = 0;
            reset_q     = 1'b1;
        end else begin
            if (reset_q && (valid_o !== 1'b0 || ready_o !== 1'b1)) begin
                $display("MISMATCH @%0t: after reset valid_o is %b and ready_o is %b",
                         $time, valid_o, ready_o);
                err_cnt_o++;
            end
            reset_q = 1'b0;
            if (ready_o !== ~(valid_o & ~ready_i)) begin
                $display("MISMATCH @%0t: ready_o is %b against the stall rule",
                         $time, ready_o);
                err_cnt_o++;
            end
            if (valid_o && ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("response at %0t with no request outstanding", $time);
                    err_cnt_o++;
                end else begin
                    exp_rsp = exp_q.pop_front();
                    due     = due_q.pop_front() + stalls;
                    check_cnt_o++;
                    if (rsp_o.tag !== exp_rsp.tag) begin
                        $display("MISMATCH @%0t: tag expected %0h, got %0h",
                                 $time, exp_rsp.tag, rsp_o.tag);
                        err_cnt_o++;
                    end
                    for (int i = 0; i < LANES; i++) begin
                        if (rsp_o.result[i] !== exp_rsp.result[i] ||
                            rsp_o.nx[i] !== exp_rsp.nx[i]) begin
                            $display("MISMATCH @%0t: tag %0h lane %0d exp %h/%b got %h/%b",
                                     $time, exp_rsp.tag, i, exp_rsp.result[i], exp_rsp.nx[i],
                                     rsp_o.result[i], rsp_o.nx[i]);
                            err_cnt_o++;
                        end
                    end
                    if (cycle != due) begin
                        $display("MISMATCH @%0t: tag %0h latency off by %0d cycles",
                                 $time, exp_rsp.tag, cycle - due);
                        err_cnt_o++;
                    end
                end
            end
            if (valid_o && !ready_i) begin
                stalls++;
            end
            if (valid_i && ready_o) begin
                exp_q.push_back(expected_response(req_i));
                due_q.push_back(cycle + 4 - stalls);
            end
            cycle++;
        end
        pending_o = exp_q.size();
    end

endmodule

// ==== source/cvt_itof.sv ====
`timescale 1ns/1ps

module cvt_itof (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              valid_i,
    output logic              ready_o,
    input  cvt_pkg::cvt_req_t req_i,
    output logic              valid_o,
    input  logic              ready_i,
    output cvt_pkg::cvt_rsp_t rsp_o
);

    import cvt_pkg::*;

    logic                        en;   // global pipeline enable
    logic [LANES-1:0][INT_W-1:0] data_s0;
    logic                        signed_s0;
    rnd_mode_e                   rnd_s1;
    logic                        valid_s2;
    logic [TAG_W-1:0]            tag_s2;
    cvt_lane_rsp_t [LANES-1:0]   lane_rsp;

    cvt_issue u_issue (
        .clk         (clk),
        .reset_i     (reset_i),
        .en_i        (en),
        .valid_i     (valid_i),
        .req_i       (req_i),
        .valid_s0_o  (),
        .data_s0_o   (data_s0),
        .signed_s0_o (signed_s0),
        .rnd_s1_o    (rnd_s1),
        .valid_s2_o  (valid_s2),
        .tag_s2_o    (tag_s2)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        cvt_lane u_lane (
            .clk        (clk),
            .en_i       (en),
            .data_i     (data_s0[i]),
            .signed_i   (signed_s0),
            .rnd_mode_i (rnd_s1),
            .rsp_o      (lane_rsp[i])
        );
    end

    cvt_collect u_collect (
        .clk        (clk),
        .reset_i    (reset_i),
        .ready_i    (ready_i),
        .valid_s2_i (valid_s2),
        .tag_s2_i   (tag_s2),
        .lane_rsp_i (lane_rsp),
        .en_o       (en),
        .ready_o    (ready_o),
        .valid_o    (valid_o),
        .rsp_o      (rsp_o)
    );

endmodule

// ==== source/cvt_collect.sv ====
`timescale 1ns/1ps

module cvt_collect (
    input  logic                                       clk,
    input  logic                                       reset_i,
    input  logic                                       ready_i,
    input  logic                                       valid_s2_i,
    input  logic [cvt_pkg::TAG_W-1:0]                  tag_s2_i,
    input  cvt_pkg::cvt_lane_rsp_t [cvt_pkg::LANES-1:0] lane_rsp_i,
    output logic                                       en_o,
    output logic                                       ready_o,
    output logic                                       valid_o,
    output cvt_pkg::cvt_rsp_t                          rsp_o
);

    import cvt_pkg::*;

    logic     stall;
    cvt_rsp_t rsp_s2;

    // gather lanes and tag into one response
    always_comb begin
        rsp_s2.tag = tag_s2_i;
        for (int i = 0; i < LANES; i++) begin
            rsp_s2.result[i] = lane_rsp_i[i].result;
            rsp_s2.nx[i]     = lane_rsp_i[i].nx;
        end
    end

    assign stall   = valid_o & ~ready_i;   // output held with nobody taking it
    assign en_o    = ~stall;
    assign ready_o = ~stall;

    cvt_pipe_reg #(
        .payload_t (cvt_rsp_t)
    ) u_reg_out (
        .clk     (clk),
        .reset_i (reset_i),
        .en_i    (en_o),
        .valid_i (valid_s2_i),
        .data_i  (rsp_s2),
        .valid_o (valid_o),
        .data_o  (rsp_o)
    );

    // a pending response must not change under back-pressure
    a_hold_on_stall: assert property (@(posedge clk) disable iff (reset_i)
        stall |=> $stable(valid_o) && $stable(rsp_o));

endmodule

// ==== source/cvt_lane.sv ====
`timescale 1ns/1ps

module cvt_lane (
    input  logic                      clk,
    input  logic                      en_i,
    input  logic [cvt_pkg::INT_W-1:0] data_i,
    input  logic                      signed_i,
    input  cvt_pkg::rnd_mode_e        rnd_mode_i,
    output cvt_pkg::cvt_lane_rsp_t    rsp_o
);

    import cvt_pkg::*;

    logic                sign_s0;
    logic [INT_W-1:0]    mag_s0;
    logic [LZC_W-1:0]    lzc_count;
    logic                mag_zero;
    cvt_norm_t           norm_s0;
    cvt_norm_t           norm_s1;
    logic [MAN_BITS-1:0] man_s1;
    logic                guard_s1;
    logic                sticky_s1;
    logic [FLT_W-1:0]    packed_s1;
    logic [FLT_W-1:0]    rounded_s1;
    logic                inexact_s1;
    cvt_lane_rsp_t       rsp_s1;

    // stage 0 takes the magnitude and normalizes

    assign sign_s0 = signed_i & data_i[INT_W-1];
    assign mag_s0  = sign_s0 ? -data_i : data_i;   // min int wraps to 2^31 which is right unsigned

    cvt_lzc u_lzc (
        .data_i  (mag_s0),
        .count_o (lzc_count),
        .zero_o  (mag_zero)
    );

    always_comb begin
        norm_s0.sign = sign_s0;
        norm_s0.zero = mag_zero;
        norm_s0.exp  = EXP_BITS'(EXP_BIAS + INT_W - 1 - lzc_count);
        norm_s0.mant = mag_s0 << lzc_count;   // leading one to the msb
    end

    // issue's valid qualifies the lane data
    cvt_pipe_reg #(
        .payload_t (cvt_norm_t)
    ) u_reg_norm (
        .clk     (clk),
        .reset_i (1'b0),
        .en_i    (en_i),
        .valid_i (1'b1),
        .data_i  (norm_s0),
        .valid_o (),
        .data_o  (norm_s1)
    );

    // stage 1 drops the hidden one and rounds

    assign man_s1    = norm_s1.mant[INT_W-2 -: MAN_BITS];
    assign guard_s1  = norm_s1.mant[INT_W-2-MAN_BITS];
    assign sticky_s1 = |norm_s1.mant[INT_W-3-MAN_BITS:0];
    assign packed_s1 = {1'b0, norm_s1.exp, man_s1};

    cvt_round u_round (
        .mag_i      (packed_s1),
        .sign_i     (norm_s1.sign),
        .guard_i    (guard_s1),
        .sticky_i   (sticky_s1),
        .rnd_mode_i (rnd_mode_i),
        .mag_o      (rounded_s1),
        .inexact_o  (inexact_s1)
    );

    always_comb begin
        if (norm_s1.zero) begin
            rsp_s1.result = '0;   // integer zero gives +0
            rsp_s1.nx     = 1'b0;
        end else begin
            rsp_s1.result = {norm_s1.sign, rounded_s1[FLT_W-2:0]};
            rsp_s1.nx     = inexact_s1;
        end
    end

    cvt_pipe_reg #(
        .payload_t (cvt_lane_rsp_t)
    ) u_reg_rsp (
        .clk     (clk),
        .reset_i (1'b0),
        .en_i    (en_i),
        .valid_i (1'b1),
        .data_i  (rsp_s1),
        .valid_o (),
        .data_o  (rsp_o)
    );

endmodule

// ==== source/cvt_issue.sv ====
`timescale 1ns/1ps

module cvt_issue (
    input  logic                                      clk,
    input  logic                                      reset_i,
    input  logic                                      en_i,
    input  logic                                      valid_i,
    input  cvt_pkg::cvt_req_t                         req_i,
    output logic                                      valid_s0_o,
    output logic [cvt_pkg::LANES-1:0][cvt_pkg::INT_W-1:0] data_s0_o,
    output logic                                      signed_s0_o,
    output cvt_pkg::rnd_mode_e                        rnd_s1_o,
    output logic                                      valid_s2_o,
    output logic [cvt_pkg::TAG_W-1:0]                 tag_s2_o
);

    import cvt_pkg::*;

    cvt_req_t  req_s0;
    cvt_ctrl_t ctrl_s0;
    cvt_ctrl_t ctrl_s1;
    cvt_ctrl_t ctrl_s2;
    logic      valid_s1;

    cvt_pipe_reg #(
        .payload_t (cvt_req_t)
    ) u_reg_s0 (
        .clk     (clk),
        .reset_i (reset_i),
        .en_i    (en_i),
        .valid_i (valid_i),
        .data_i  (req_i),
        .valid_o (valid_s0_o),
        .data_o  (req_s0)
    );

    // only control goes further down
    always_comb begin
        ctrl_s0.tag      = req_s0.tag;
        ctrl_s0.rnd_mode = req_s0.rnd_mode;
    end

    cvt_pipe_reg #(
        .payload_t (cvt_ctrl_t)
    ) u_reg_s1 (
        .clk     (clk),
        .reset_i (reset_i),
        .en_i    (en_i),
        .valid_i (valid_s0_o),
        .data_i  (ctrl_s0),
        .valid_o (valid_s1),
        .data_o  (ctrl_s1)
    );

    cvt_pipe_reg #(
        .payload_t (cvt_ctrl_t)
    ) u_reg_s2 (
        .clk     (clk),
        .reset_i (reset_i),
        .en_i    (en_i),
        .valid_i (valid_s1),
        .data_i  (ctrl_s1),
        .valid_o (valid_s2_o),
        .data_o  (ctrl_s2)
    );

    assign data_s0_o   = req_s0.data;
    assign signed_s0_o = req_s0.is_signed;
    assign rnd_s1_o    = ctrl_s1.rnd_mode;   // lanes round in stage 1
    assign tag_s2_o    = ctrl_s2.tag;

endmodule

// ==== source/cvt_round.sv ====
`timescale 1ns/1ps

module cvt_round (
    input  logic [cvt_pkg::FLT_W-1:0] mag_i,
    input  logic                      sign_i,
    input  logic                      guard_i,
    input  logic                      sticky_i,
    input  cvt_pkg::rnd_mode_e        rnd_mode_i,
    output logic [cvt_pkg::FLT_W-1:0] mag_o,
    output logic                      inexact_o
);

    import cvt_pkg::*;

    logic round_up;

    always_comb begin
        case (rnd_mode_i)
            RNE:     round_up = guard_i & (sticky_i | mag_i[0]);   // ties to even
            RTZ:     round_up = 1'b0;
            RDN:     round_up = sign_i & (guard_i | sticky_i);
            RUP:     round_up = ~sign_i & (guard_i | sticky_i);
            RMM:     round_up = guard_i;   // ties away from zero
            default: round_up = 1'b0;
        endcase
    end

    // exp and mantissa are packed, so a mantissa carry bumps the exponent
    assign mag_o = mag_i + FLT_W'(round_up);

    assign inexact_o = guard_i | sticky_i;

endmodule

// ==== source/cvt_lzc.sv ====
`timescale 1ns/1ps

module cvt_lzc (
    input  logic [cvt_pkg::INT_W-1:0] data_i,
    output logic [cvt_pkg::LZC_W-1:0] count_o,
    output logic                      zero_o
);

    import cvt_pkg::*;

    // priority search from the msb down
    always_comb begin
        count_o = '0;
        zero_o  = 1'b1;
        for (int i = INT_W - 1; i >= 0; i--) begin
            if (zero_o && data_i[i]) begin
                count_o = LZC_W'(INT_W - 1 - i);
                zero_o  = 1'b0;   // first one found
            end
        end
    end

    // count must point at the leading one
    a_lzc_hit: assert final (zero_o || data_i[INT_W - 1 - count_o]);

endmodule

// ==== source/cvt_pipe_reg.sv ====
`timescale 1ns/1ps

module cvt_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     en_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else if (en_i) begin
            valid_o <= valid_i;
        end
    end

    // payload only moves with the enable
    always_ff @(posedge clk) begin
        if (en_i) begin
            data_o <= data_i;
        end
    end

    // once valid is known it must stay known
    a_valid_known: assert property (@(posedge clk) disable iff (reset_i)
        !$isunknown($past(valid_o)) |-> !$isunknown(valid_o));

endmodule

// ==== source/cvt_pkg.sv ====
package cvt_pkg;

    localparam int LANES    = 4;
    localparam int TAG_W    = 4;
    localparam int INT_W    = 32;
    localparam int FLT_W    = 32;
    localparam int MAN_BITS = 23;
    localparam int EXP_BITS = 8;
    localparam int EXP_BIAS = 127;
    localparam int LZC_W    = 5;   // enough to count 0..31 leading zeros

    // rounding modes, encoded as in the fcsr frm field
    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } rnd_mode_e;

    typedef struct packed {
        logic [TAG_W-1:0]            tag;
        rnd_mode_e                   rnd_mode;
        logic                        is_signed;
        logic [LANES-1:0][INT_W-1:0] data;
    } cvt_req_t;

    // control shared by all lanes
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        rnd_mode_e        rnd_mode;
    } cvt_ctrl_t;

    typedef struct packed {
        logic                sign;
        logic                zero;
        logic [EXP_BITS-1:0] exp;    // biased
        logic [INT_W-1:0]    mant;   // leading one at the msb
    } cvt_norm_t;

    typedef struct packed {
        logic [FLT_W-1:0] result;
        logic             nx;
    } cvt_lane_rsp_t;

    typedef struct packed {
        logic [TAG_W-1:0]            tag;
        logic [LANES-1:0][FLT_W-1:0] result;
        logic [LANES-1:0]            nx;
    } cvt_rsp_t;

endpackage
